/* Makefile */
# Verilator build for the arcade host side testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_arcade_io
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the simulator output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+.
arcade_pkg.sv
ps2_keyboard.sv
control_mapper.sv
video_output.sv
audio_dac.sv
arcade_io_top.sv
arcade_io_chk.sv
tb_arcade_io.sv

/* arcade_defines.svh */
`ifndef ARCADE_DEFINES_SVH
`define ARCADE_DEFINES_SVH

// Width of one game audio sample
`define ARCADE_SAMPLE_W 10

// Number of bits in the held-key vector, the top bit is the skip key
`define ARCADE_KEY_COUNT 10

// System clock cycles per pixel clock enable
`define ARCADE_PIX_DIV 4

// PS/2 set 2 scancodes for the cabinet controls
// The four arrows only count when they follow the extended prefix
`define ARCADE_SC_UP     8'h75
`define ARCADE_SC_DOWN   8'h72
`define ARCADE_SC_LEFT   8'h6B
`define ARCADE_SC_RIGHT  8'h74
`define ARCADE_SC_FIRE   8'h29
`define ARCADE_SC_START1 8'h16
`define ARCADE_SC_START2 8'h1E
`define ARCADE_SC_COIN   8'h2E
`define ARCADE_SC_SKIP   8'h0D

// Prefix bytes that modify the code that follows
`define ARCADE_SC_BREAK  8'hF0
`define ARCADE_SC_EXT    8'hE0

`endif

/* arcade_io_chk.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module arcade_io_chk import arcade_pkg::*; (
	input logic     clk_sys,
	input logic     arst_n,
	input key_vec_t keys,
	input joy_t     joystick_0,
	input joy_t     joystick_1,
	input logic     rotate,
	input game_in_t game_in0,
	input game_in_t game_in1,
	input logic     ce_pix,
	input colour3_t r,
	input colour3_t g,
	input colour2_t b,
	input logic     hblank,
	input logic     vblank,
	input logic     hsync,
	input logic     vsync,
	input colour6_t vga_r,
	input colour6_t vga_g,
	input colour6_t vga_b,
	input logic     vga_hs,
	input logic     vga_vs
);

	// Failure counts per rule, summed for the testbench
	int map_fails = 0;
	int ce_fails = 0;
	int video_fails = 0;
	int fail_cnt;

	// Cycles since the last pixel enable, and whether one was seen yet
	int   since;
	logic seen;

	assign fail_cnt = map_fails + ce_fails + video_fails;

	// ====================================================================
	// Reference rules for the game input bytes and the colour channels
	// ====================================================================

	// Bit 7 down to 0 is zero, fire, coin, skip, down, right, left, up
	function automatic game_in_t expect_in0(key_vec_t k, joy_t j0, joy_t j1, logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		up    = k[7] | j0[3] | j1[3];
		down  = k[6] | j0[2] | j1[2];
		left  = k[5] | j0[1] | j1[1];
		right = k[4] | j0[0] | j1[0];
		fire  = k[0] | j0[4] | j1[4];
		// Turned cabinet, so up reads left, down reads right and so on
		if (rot)
			return ~{1'b0, fire, k[3], k[9], right, up, down, left};
		return ~{1'b0, fire, k[3], k[9], down, right, left, up};
	endfunction

	function automatic game_in_t expect_in1(key_vec_t k);
		return ~{1'b0, k[2], k[1], 5'b00000};
	endfunction

	function automatic colour6_t expand3(colour3_t c, logic blank);
		return blank ? 6'd0 : {c, c};
	endfunction

	function automatic colour6_t expand2(colour2_t c, logic blank);
		return blank ? 6'd0 : {c, c, c};
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			since <= 0;
			seen  <= 1'b0;
		end else if (ce_pix) begin
			since <= 1;
			seen  <= 1'b1;
		end else if (since < 2 * `ARCADE_PIX_DIV) begin
			since <= since + 1;
		end
	end

	// ====================================================================
	// Assertions
	// ====================================================================

	// Registered bytes follow the inputs of the cycle before
	map_rule: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$past(arst_n) |-> (game_in0 == expect_in0($past(keys), $past(joystick_0),
			$past(joystick_1), $past(rotate))) && (game_in1 == expect_in1($past(keys))))
	else begin
		$error("game input bytes do not follow the control mapping");
		map_fails++;
	end

	// Once running, the enable shows up on every fourth cycle and only then
	ce_rule: assert property (@(posedge clk_sys) disable iff (!arst_n)
		seen |-> (ce_pix == (since == `ARCADE_PIX_DIV)))
	else begin
		$error("pixel enable does not recur at the divider period");
		ce_fails++;
	end

	video_rule: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_pix |=> (vga_r == expand3($past(r), $past(hblank | vblank)))
			&& (vga_g == expand3($past(g), $past(hblank | vblank)))
			&& (vga_b == expand2($past(b), $past(hblank | vblank)))
			&& (vga_hs == $past(hsync)) && (vga_vs == $past(vsync)))
	else begin
		$error("video outputs do not match the inputs taken at the pixel enable");
		video_fails++;
	end

endmodule

// Attached at the top level, where the mapper and video ports meet
bind arcade_io_top arcade_io_chk u_chk (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.keys       (keys),
	.joystick_0 (joystick_0),
	.joystick_1 (joystick_1),
	.rotate     (rotate),
	.game_in0   (game_in0),
	.game_in1   (game_in1),
	.ce_pix     (ce_pix),
	.r          (r),
	.g          (g),
	.b          (b),
	.hblank     (hblank),
	.vblank     (vblank),
	.hsync      (hsync),
	.vsync      (vsync),
	.vga_r      (vga_r),
	.vga_g      (vga_g),
	.vga_b      (vga_b),
	.vga_hs     (vga_hs),
	.vga_vs     (vga_vs)
);

/* arcade_io_top.sv */
`timescale 1ns/1ns

module arcade_io_top import arcade_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     ps2_clk,
	input  logic     ps2_data,
	input  joy_t     joystick_0,
	input  joy_t     joystick_1,
	input  logic     rotate,
	input  colour3_t r,
	input  colour3_t g,
	input  colour2_t b,
	input  logic     hblank,
	input  logic     vblank,
	input  logic     hsync,
	input  logic     vsync,
	input  sample_t  audio,
	output game_in_t game_in0,
	output game_in_t game_in1,
	output logic     ce_pix,
	output colour6_t vga_r,
	output colour6_t vga_g,
	output colour6_t vga_b,
	output logic     vga_hs,
	output logic     vga_vs,
	output logic     audio_l,
	output logic     audio_r
);

	// Held keys from the keyboard receiver
	key_vec_t keys;

	// ====================================================================
	// Player inputs
	// ====================================================================

	ps2_keyboard u_ps2_keyboard (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.keys     (keys)
	);

	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.game_in0   (game_in0),
		.game_in1   (game_in1)
	);

	// ====================================================================
	// Video and audio
	// ====================================================================

	video_output u_video_output (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.r       (r),
		.g       (g),
		.b       (b),
		.hblank  (hblank),
		.vblank  (vblank),
		.hsync   (hsync),
		.vsync   (vsync),
		.ce_pix  (ce_pix),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	audio_dac u_audio_dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.audio   (audio),
		.audio_l (audio_l)
	);

	// The cabinet has mono sound, so both channels carry the same stream
	assign audio_r = audio_l;

endmodule

/* arcade_pkg.sv */
`include "arcade_defines.svh"

package arcade_pkg;

	// ====================================================================
	// Vector types shared by the host side blocks
	// ====================================================================

	// One audio sample from the game core, unsigned
	typedef logic [`ARCADE_SAMPLE_W-1:0] sample_t;

	// Held keys, one level per control
	// Bits 0..3 are fire, start1, start2 and coin
	// Bits 4..7 are right, left, down and up
	// Bit 8 is reserved and bit 9 is skip
	typedef logic [`ARCADE_KEY_COUNT-1:0] key_vec_t;

	// Joystick port, bits 0..4 are right, left, down, up and fire
	typedef logic [7:0] joy_t;

	// Active low input byte as the game core reads it
	typedef logic [7:0] game_in_t;

	// Colour channels as the game core produces them
	typedef logic [2:0] colour3_t;
	typedef logic [1:0] colour2_t;

	// Colour channel as the VGA pins take it
	typedef logic [5:0] colour6_t;

	// PS/2 receiver states, the start bit is taken in idle
	typedef enum logic [1:0] {
		st_idle,
		st_data,
		st_parity,
		st_stop
	} ps2_state_t;

endpackage

/* audio_dac.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module audio_dac import arcade_pkg::*; (
	input  logic    clk_sys,
	input  logic    arst_n,
	input  sample_t audio,
	output logic    audio_l
);

	// The low bits hold the running remainder between cycles
	logic [`ARCADE_SAMPLE_W-1:0] acc;

	// One extra bit on top catches the carry
	logic [`ARCADE_SAMPLE_W:0]   sum;

	// ====================================================================
	// First order sigma-delta
	// ====================================================================

	assign sum = {1'b0, acc} + {1'b0, audio};

	// Carry out rate over a full wrap equals the sample value
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc     <= '0;
			audio_l <= 1'b0;
		end else begin
			acc     <= sum[`ARCADE_SAMPLE_W-1:0];
			audio_l <= sum[`ARCADE_SAMPLE_W];
		end
	end

endmodule

/* control_mapper.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module control_mapper import arcade_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  key_vec_t keys,
	input  joy_t     joystick_0,
	input  joy_t     joystick_1,
	input  logic     rotate,
	output game_in_t game_in0,
	output game_in_t game_in1
);

	// Positions in the held-key vector, skip sits at the very top
	localparam int unsigned key_fire   = 0;
	localparam int unsigned key_start1 = 1;
	localparam int unsigned key_start2 = 2;
	localparam int unsigned key_coin   = 3;
	localparam int unsigned key_skip   = `ARCADE_KEY_COUNT - 1;

	// Each direction merged over keyboard and both joysticks
	logic src_right;
	logic src_left;
	logic src_down;
	logic src_up;

	// Directions after the cabinet orientation is applied
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	assign src_right = keys[4] | joystick_0[0] | joystick_1[0];
	assign src_left  = keys[5] | joystick_0[1] | joystick_1[1];
	assign src_down  = keys[6] | joystick_0[2] | joystick_1[2];
	assign src_up    = keys[7] | joystick_0[3] | joystick_1[3];

	// A turned cabinet rotates the stick a quarter turn
	assign m_up    = rotate ? src_left  : src_up;
	assign m_down  = rotate ? src_right : src_down;
	assign m_left  = rotate ? src_down  : src_left;
	assign m_right = rotate ? src_up    : src_right;

	assign m_fire = keys[key_fire] | joystick_0[4] | joystick_1[4];

	// ====================================================================
	// Registered game input bytes, active low
	// ====================================================================

	// All ones means nothing is pressed
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_in0 <= 8'hFF;
			game_in1 <= 8'hFF;
		end else begin
			game_in0 <= ~{1'b0, m_fire, keys[key_coin], keys[key_skip],
				m_down, m_right, m_left, m_up};
			game_in1 <= ~{1'b0, keys[key_start2], keys[key_start1], 5'b00000};
		end
	end

endmodule

/* ps2_keyboard.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module ps2_keyboard import arcade_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     ps2_clk,
	input  logic     ps2_data,
	output key_vec_t keys
);

	// ====================================================================
	// Line synchronisers and falling edge detect
	// ====================================================================

	logic       clk_meta;
	logic       clk_sync;
	logic       clk_prev;
	logic       data_meta;
	logic       data_sync;
	logic       clk_fall;

	// Frame receiver state
	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       parity_acc;

	// Prefix flags and the scancode lookup result
	logic       brk_flag;
	logic       ext_flag;
	logic       key_hit;
	logic [3:0] key_idx;

	// The keyboard idles both lines high, so reset to that level
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			clk_prev  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk;
			clk_sync  <= clk_meta;
			clk_prev  <= clk_sync;
			data_meta <= ps2_data;
			data_sync <= data_meta;
		end
	end

	// Data is valid on the falling edge of the keyboard clock
	assign clk_fall = clk_prev & ~clk_sync;

	// ====================================================================
	// Scancode lookup
	// ====================================================================

	// Arrows need the extended prefix, a bare 75 is keypad 8
	always_comb begin
		key_hit = 1'b1;
		key_idx = 4'd0;
		case (shift)
			`ARCADE_SC_FIRE:   key_idx = 4'd0;
			`ARCADE_SC_START1: key_idx = 4'd1;
			`ARCADE_SC_START2: key_idx = 4'd2;
			`ARCADE_SC_COIN:   key_idx = 4'd3;
			`ARCADE_SC_SKIP:   key_idx = 4'd9;
			`ARCADE_SC_RIGHT: begin
				key_idx = 4'd4;
				key_hit = ext_flag;
			end
			`ARCADE_SC_LEFT: begin
				key_idx = 4'd5;
				key_hit = ext_flag;
			end
			`ARCADE_SC_DOWN: begin
				key_idx = 4'd6;
				key_hit = ext_flag;
			end
			`ARCADE_SC_UP: begin
				key_idx = 4'd7;
				key_hit = ext_flag;
			end
			default: key_hit = 1'b0;
		endcase
	end

	// ====================================================================
	// Frame receiver and key tracking
	// ====================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			bit_cnt    <= 3'd0;
			parity_acc <= 1'b0;
			brk_flag   <= 1'b0;
			ext_flag   <= 1'b0;
			keys       <= '0;
		end else if (clk_fall) begin
			case (state)
				st_idle: begin
					bit_cnt    <= 3'd0;
					parity_acc <= 1'b0;
					if (!data_sync) begin
						state <= st_data;
					end else begin
						// A high start bit is a broken frame
						brk_flag <= 1'b0;
						ext_flag <= 1'b0;
					end
				end
				st_data: begin
					// Bits arrive LSB first
					shift      <= {data_sync, shift[7:1]};
					parity_acc <= parity_acc ^ data_sync;
					bit_cnt    <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= st_parity;
				end
				st_parity: begin
					// After this the accumulator is 1 for odd parity
					parity_acc <= parity_acc ^ data_sync;
					state      <= st_stop;
				end
				st_stop: begin
					state <= st_idle;
					if (data_sync && parity_acc) begin
						if (shift == `ARCADE_SC_BREAK) begin
							brk_flag <= 1'b1;
						end else if (shift == `ARCADE_SC_EXT) begin
							ext_flag <= 1'b1;
						end else begin
							if (key_hit)
								keys[key_idx] <= ~brk_flag;
							brk_flag <= 1'b0;
							ext_flag <= 1'b0;
						end
					end else begin
						// Bad parity or stop bit drops any pending prefix
						brk_flag <= 1'b0;
						ext_flag <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* tb_arcade_io.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module tb_arcade_io import arcade_pkg::*; ();

	logic     clk_sys;
	logic     arst_n;
	logic     ps2_clk;
	logic     ps2_data;
	joy_t     joystick_0;
	joy_t     joystick_1;
	logic     rotate;
	colour3_t r;
	colour3_t g;
	colour2_t b;
	logic     hblank;
	logic     vblank;
	logic     hsync;
	logic     vsync;
	sample_t  audio;
	game_in_t game_in0;
	game_in_t game_in1;
	logic     ce_pix;
	colour6_t vga_r;
	colour6_t vga_g;
	colour6_t vga_b;
	logic     vga_hs;
	logic     vga_vs;
	logic     audio_l;
	logic     audio_r;

	integer seed;
	int     err_cnt;
	int     tests_run;
	int     tests_failed;
	int     test_base;

	// Arrow scancodes in the order up, down, left, right
	logic [7:0] arrow_code [4];
	// Expected game_in0 per arrow, first index is the rotate setting
	logic [7:0] arrow_in0 [2][4];
	int         audio_set [4];

	arcade_io_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ====================================================================
	// Helpers
	// ====================================================================

	// Inputs always change 5 ns after the rising edge
	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#5;
		end
	endtask

	function automatic int total_errors();
		return err_cnt + DUT.u_chk.fail_cnt;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// Start bit, eight data bits LSB first, odd parity, stop bit
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			tick(4);
			ps2_clk = 1'b0;
			tick(4);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		tick(8);
	endtask

	task automatic key_event(input logic [7:0] code, input logic ext, input logic brk);
		if (ext)
			send_frame(`ARCADE_SC_EXT, 1'b0);
		if (brk)
			send_frame(`ARCADE_SC_BREAK, 1'b0);
		send_frame(code, 1'b0);
	endtask

	task automatic wait_inputs(input logic [7:0] exp0, input logic [7:0] exp1);
		int n;
		n = 0;
		while ((game_in0 !== exp0 || game_in1 !== exp1) && n < 40) begin
			tick(1);
			n++;
		end
		if (game_in0 !== exp0 || game_in1 !== exp1) begin
			$display("Timeout waiting for game inputs %h %h, still at %h %h",
				exp0, exp1, game_in0, game_in1);
			err_cnt++;
		end
	endtask

	task automatic wait_ce_pix();
		int n;
		n = 0;
		while (!ce_pix && n < 2 * `ARCADE_PIX_DIV) begin
			tick(1);
			n++;
		end
		if (!ce_pix) begin
			$display("Timeout, the pixel enable never pulsed");
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		int fails;
		fails = total_errors() - test_base;
		tests_run++;
		if (fails > 0)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, (fails == 0) ? "ok" : "failed");
		test_base = total_errors();
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================

	initial begin
		int count;
		seed = 63;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		test_base = 0;
		arst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b0;
		r = '0;
		g = '0;
		b = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		audio = '0;
		arrow_code = '{`ARCADE_SC_UP, `ARCADE_SC_DOWN, `ARCADE_SC_LEFT, `ARCADE_SC_RIGHT};
		arrow_in0 = '{'{8'hFE, 8'hF7, 8'hFD, 8'hFB}, '{8'hFB, 8'hFD, 8'hFE, 8'hF7}};
		audio_set = '{0, 100, 512, 1023};

		// Outputs are checked while reset is still held
		tick(4);
		check_byte("game_in0", game_in0, 8'hFF);
		check_byte("game_in1", game_in1, 8'hFF);
		check_byte("audio_l", {7'd0, audio_l}, 8'h00);
		check_byte("ce_pix", {7'd0, ce_pix}, 8'h00);
		check_byte("vga_r", {2'd0, vga_r}, 8'h00);
		check_byte("vga_g", {2'd0, vga_g}, 8'h00);
		check_byte("vga_b", {2'd0, vga_b}, 8'h00);
		check_byte("vga_syncs", {6'd0, vga_hs, vga_vs}, 8'h00);
		arst_n = 1'b1;
		tick(2);
		finish_test("reset values");

		// Fire on space, then starts, then coin together with skip
		key_event(`ARCADE_SC_FIRE, 1'b0, 1'b0);
		wait_inputs(8'hBF, 8'hFF);
		key_event(`ARCADE_SC_FIRE, 1'b0, 1'b1);
		wait_inputs(8'hFF, 8'hFF);
		key_event(`ARCADE_SC_START1, 1'b0, 1'b0);
		wait_inputs(8'hFF, 8'hDF);
		key_event(`ARCADE_SC_START2, 1'b0, 1'b0);
		wait_inputs(8'hFF, 8'h9F);
		key_event(`ARCADE_SC_START1, 1'b0, 1'b1);
		wait_inputs(8'hFF, 8'hBF);
		key_event(`ARCADE_SC_START2, 1'b0, 1'b1);
		wait_inputs(8'hFF, 8'hFF);
		key_event(`ARCADE_SC_COIN, 1'b0, 1'b0);
		wait_inputs(8'hDF, 8'hFF);
		key_event(`ARCADE_SC_SKIP, 1'b0, 1'b0);
		wait_inputs(8'hCF, 8'hFF);
		key_event(`ARCADE_SC_COIN, 1'b0, 1'b1);
		wait_inputs(8'hEF, 8'hFF);
		key_event(`ARCADE_SC_SKIP, 1'b0, 1'b1);
		wait_inputs(8'hFF, 8'hFF);
		finish_test("make and break codes");

		for (int rot = 0; rot < 2; rot++) begin
			rotate = rot[0];
			tick(2);
			for (int k = 0; k < 4; k++) begin
				key_event(arrow_code[k], 1'b1, 1'b0);
				wait_inputs(arrow_in0[rot][k], 8'hFF);
				key_event(arrow_code[k], 1'b1, 1'b1);
				wait_inputs(8'hFF, 8'hFF);
			end
		end
		rotate = 1'b0;
		tick(2);
		// Without the prefix 75 is keypad 8 and maps to nothing
		send_frame(`ARCADE_SC_UP, 1'b0);
		check_byte("game_in0", game_in0, 8'hFF);
		finish_test("extended arrows and rotation");

		// A make with bad parity must not press fire
		send_frame(`ARCADE_SC_FIRE, 1'b1);
		check_byte("game_in0", game_in0, 8'hFF);
		// A bad E0 after F0 drops the break so the next 29 is a make
		send_frame(`ARCADE_SC_BREAK, 1'b0);
		send_frame(`ARCADE_SC_EXT, 1'b1);
		send_frame(`ARCADE_SC_FIRE, 1'b0);
		wait_inputs(8'hBF, 8'hFF);
		key_event(`ARCADE_SC_FIRE, 1'b0, 1'b1);
		wait_inputs(8'hFF, 8'hFF);
		finish_test("parity error");

		// The bound checker judges every cycle of this random run
		wait_ce_pix();
		for (int i = 0; i < 400; i++) begin
			rotate = (i >= 200);
			joystick_0 = 8'($random(seed));
			joystick_1 = 8'($random(seed));
			r = 3'($random(seed));
			g = 3'($random(seed));
			b = 2'($random(seed));
			{hblank, vblank, hsync, vsync} = 4'($random(seed));
			tick(1);
		end
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b0;
		tick(4);
		finish_test("random joysticks and video");

		for (int k = 0; k < 4; k++) begin
			audio = 10'(audio_set[k]);
			tick(1024);
			count = 0;
			for (int i = 0; i < 1024; i++) begin
				tick(1);
				if (audio_l)
					count++;
				assert (audio_r === audio_l) else begin
					$display("Mismatch audio_r: got %h expected %h", audio_r, audio_l);
					err_cnt++;
				end
			end
			assert (count >= audio_set[k] - 1 && count <= audio_set[k] + 1) else begin
				$display("Mismatch audio_l high count: got %h expected %h",
					count, audio_set[k]);
				err_cnt++;
			end
		end
		finish_test("audio density");

		tick(2);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0 && tests_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* video_output.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module video_output import arcade_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  colour3_t r,
	input  colour3_t g,
	input  colour2_t b,
	input  logic     hblank,
	input  logic     vblank,
	input  logic     hsync,
	input  logic     vsync,
	output logic     ce_pix,
	output colour6_t vga_r,
	output colour6_t vga_g,
	output colour6_t vga_b,
	output logic     vga_hs,
	output logic     vga_vs
);

	localparam int unsigned cnt_w = $clog2(`ARCADE_PIX_DIV);

	logic [cnt_w-1:0] pix_cnt;
	logic             blank;

	// ====================================================================
	// Pixel clock enable
	// ====================================================================

	// Enable fires on the last count of each pixel period
	assign ce_pix = (pix_cnt == cnt_w'(`ARCADE_PIX_DIV - 1));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			pix_cnt <= '0;
		else if (ce_pix)
			pix_cnt <= '0;
		else
			pix_cnt <= pix_cnt + 1'b1;
	end

	// ====================================================================
	// Colour expansion and sync registering
	// ====================================================================

	assign blank = hblank | vblank;

	// Repeating the bits spreads the short channels over the full range
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (ce_pix) begin
			vga_r  <= blank ? '0 : {r, r};
			vga_g  <= blank ? '0 : {g, g};
			vga_b  <= blank ? '0 : {b, b, b};
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

endmodule
